//--- hw/qla_consts.svh
// ----------------------------------------
// Address map, register offsets, DAC framing
// and serial clock divide for the amp core
// ----------------------------------------

`ifndef QLA_CONSTS_SVH
`define QLA_CONSTS_SVH

// Board geometry
`define QLA_NUM_CHAN        4       // Motor axes on the board

// ----------------------------------------
// Address map
// ----------------------------------------
// addr[15:12]  address space
// addr[7:4]    channel, 0 = board registers
// addr[3:0]    register offset within channel
`define ADDR_MAIN           4'd0    // Main register space

// Channel 0 board registers
`define REG_STATUS          4'd0    // Board id, amp enables
`define REG_DAC_UPDATE      4'd1    // Write triggers DAC refresh

// Per-axis offsets, channels 1..4
`define OFF_DAC_CTRL        4'd1    // Commanded current
`define OFF_MOTOR_STATUS    4'd12   // Amp disable and fault bits

// ----------------------------------------
// Quad DAC serial framing
// ----------------------------------------
// Frame is {cmd[3:0], addr[3:0], data[15:0]}, MSB first
`define DAC_CMD_WRITE_UPDATE 4'h3   // Write and update DAC n
`define DAC_FRAME_BITS      24      // Bits per chip select frame

// sysclk cycles per half period of dac_sclk
`define DAC_CLK_DIV         4

`endif

//--- hw/qla_pkg.sv
// ----------------------------------------
// Shared types for the amp register core
// ----------------------------------------

package qla_pkg;

    // Bus word address, {space, -, channel, offset}
    typedef logic [15:0] reg_addr_t;

    // Bus data word
    typedef logic [31:0] reg_data_t;

    // Commanded current, straight DAC code
    typedef logic [15:0] cur_cmd_t;

    // Channel field of an address, also board id width
    typedef logic [3:0]  chan_idx_t;

    // DAC shifter states
    typedef enum logic [1:0] {
        DAC_IDLE   = 2'd0,  // Waiting for update request
        DAC_SELECT = 2'd1,  // Chip select low, first half bit
        DAC_SHIFT  = 2'd2,  // Clocking frame bits out
        DAC_GAP    = 2'd3   // Chip select high between frames
    } dac_state_t;

endpackage

//--- hw/qla_bus_slave.sv
// ----------------------------------------
// Wishbone classic slave, board register
// decode and read data mux
// ----------------------------------------

`timescale 1ns/1ps
`include "qla_consts.svh"

module qla_bus_slave (
    input  logic                       sysclk,
    input  logic                       reset,
    // Wishbone classic slave
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  qla_pkg::reg_addr_t         wb_adr,
    input  qla_pkg::reg_data_t         wb_dat_w,
    output qla_pkg::reg_data_t         wb_dat_r,
    output logic                       wb_ack,
    // Board state for reads
    input  qla_pkg::chan_idx_t         board_id,
    input  logic [`QLA_NUM_CHAN-1:0]   amp_disable_pin,   // Channel 1 in bit 0
    input  qla_pkg::cur_cmd_t          ch_cur_cmd1,
    input  qla_pkg::cur_cmd_t          ch_cur_cmd2,
    input  qla_pkg::cur_cmd_t          ch_cur_cmd3,
    input  qla_pkg::cur_cmd_t          ch_cur_cmd4,
    input  qla_pkg::reg_data_t         ch_status1,
    input  qla_pkg::reg_data_t         ch_status2,
    input  qla_pkg::reg_data_t         ch_status3,
    input  qla_pkg::reg_data_t         ch_status4,
    // Internal write bus
    output logic                       reg_wen,
    output qla_pkg::reg_addr_t         reg_waddr,
    output qla_pkg::reg_data_t         reg_wdata,
    output logic                       amp_cmd_wen,
    output logic                       dac_update_req
);
    import qla_pkg::*;

    logic       ack_q;
    logic       req_take;       // New request seen this cycle
    logic       adr_main;
    chan_idx_t  adr_chan;
    logic [3:0] adr_off;
    logic       brd_wr;         // Write to channel 0 registers
    cur_cmd_t   cur_sel;
    reg_data_t  stat_sel;
    reg_data_t  rd_word;
    reg_data_t  rd_q;

    assign adr_main = (wb_adr[15:12] == `ADDR_MAIN);
    assign adr_chan = wb_adr[7:4];
    assign adr_off  = wb_adr[3:0];

    // ack stays low for a cycle after each acknowledge
    assign req_take = wb_cyc & wb_stb & ~ack_q;
    assign brd_wr   = req_take & wb_we & adr_main & (adr_chan == 4'd0);

    // ----------------------------------------
    // Ack and write strobes
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            ack_q          <= 1'b0;
            reg_wen        <= 1'b0;
            amp_cmd_wen    <= 1'b0;
            dac_update_req <= 1'b0;
        end else begin
            ack_q          <= req_take;
            reg_wen        <= req_take & wb_we;                 // High with ack
            amp_cmd_wen    <= brd_wr & (adr_off == `REG_STATUS);
            dac_update_req <= brd_wr & (adr_off == `REG_DAC_UPDATE);
        end
    end

    // Payload captured with the request
    always_ff @(posedge sysclk) begin
        if (req_take) begin
            reg_waddr <= wb_adr;
            reg_wdata <= wb_dat_w;
            rd_q      <= rd_word;       // Read word valid during ack
        end
    end

    // ----------------------------------------
    // Read data mux
    // ----------------------------------------
    always_comb begin
        case (adr_chan)
            4'd1: begin cur_sel = ch_cur_cmd1; stat_sel = ch_status1; end
            4'd2: begin cur_sel = ch_cur_cmd2; stat_sel = ch_status2; end
            4'd3: begin cur_sel = ch_cur_cmd3; stat_sel = ch_status3; end
            4'd4: begin cur_sel = ch_cur_cmd4; stat_sel = ch_status4; end
            default: begin
                cur_sel  = '0;          // No such axis
                stat_sel = '0;
            end
        endcase
    end

    always_comb begin
        rd_word = '0;                   // Unmapped reads return zero
        if (adr_main && adr_chan == 4'd0) begin
            if (adr_off == `REG_STATUS)
                rd_word = {4'd0, board_id, 20'd0, amp_disable_pin};
        end else if (adr_main) begin
            if (adr_off == `OFF_DAC_CTRL)
                rd_word = {16'd0, cur_sel};
            else if (adr_off == `OFF_MOTOR_STATUS)
                rd_word = stat_sel;
        end
    end

    assign wb_ack   = ack_q;
    assign wb_dat_r = rd_q;

endmodule

//--- hw/motor_channel.sv
// ----------------------------------------
// One axis: commanded current, amp disable,
// fault latch and motor status word
// ----------------------------------------

`timescale 1ns/1ps
`include "qla_consts.svh"

module motor_channel #(
    parameter int CHANNEL = 1               // Axis number, 1..4
) (
    input  logic                sysclk,
    input  logic                reset,
    input  logic                reg_wen,
    input  qla_pkg::reg_addr_t  reg_waddr,
    input  qla_pkg::reg_data_t  reg_wdata,
    input  logic                amp_cmd_wen,  // Board status write
    input  logic                amp_fault_n,  // Amp fault pin, active low
    output qla_pkg::cur_cmd_t   cur_cmd,
    output logic                amp_disable_pin,
    output qla_pkg::reg_data_t  status
);
    import qla_pkg::*;

    // Bit positions in the board status write word
    localparam int MASK_BIT = 8 + CHANNEL - 1;
    localparam int EN_BIT   = CHANNEL - 1;

    logic       cmd_sel;        // Write hits this axis' current register
    logic       amp_sel;        // Board status write masks this axis
    logic [1:0] fault_sync;     // Two-flop synchroniser, [1] is stable
    logic       fault_now;
    logic       fault_latch;
    logic       host_disable;   // Disable requested by the host

    assign cmd_sel = reg_wen
                   && (reg_waddr[15:12] == `ADDR_MAIN)
                   && (reg_waddr[7:4] == chan_idx_t'(CHANNEL))
                   && (reg_waddr[3:0] == `OFF_DAC_CTRL);

    assign amp_sel   = amp_cmd_wen & reg_wdata[MASK_BIT];
    assign fault_now = ~fault_sync[1];

    // ----------------------------------------
    // Commanded current
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset)
            cur_cmd <= '0;
        else if (cmd_sel)
            cur_cmd <= reg_wdata[15:0];     // Low half is the DAC code
    end

    // ----------------------------------------
    // Fault sync, latch and enables
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            fault_sync      <= 2'b11;       // Pin idles high
            fault_latch     <= 1'b0;
            host_disable    <= 1'b1;        // Amps start disabled
            amp_disable_pin <= 1'b1;
        end else begin
            fault_sync <= {fault_sync[0], amp_fault_n};
            // Live fault wins over a clearing enable
            if (fault_now)
                fault_latch <= 1'b1;
            else if (amp_sel && reg_wdata[EN_BIT])
                fault_latch <= 1'b0;
            if (amp_sel)
                host_disable <= ~reg_wdata[EN_BIT];
            amp_disable_pin <= host_disable | fault_latch;  // One cycle after latch
        end
    end

    // Bit 2 is the synchronised pin level, 0 while faulted
    assign status = {29'd0, fault_sync[1], fault_latch, amp_disable_pin};

endmodule

//--- hw/dac_spi_ctrl.sv
// ----------------------------------------
// DAC update request latch and serial
// shifter for four quad DAC frames
// ----------------------------------------

`timescale 1ns/1ps
`include "qla_consts.svh"

module dac_spi_ctrl (
    input  logic               sysclk,
    input  logic               reset,
    input  logic               dac_update_req,  // One-cycle host request
    input  qla_pkg::cur_cmd_t  cur_cmd1,
    input  qla_pkg::cur_cmd_t  cur_cmd2,
    input  qla_pkg::cur_cmd_t  cur_cmd3,
    input  qla_pkg::cur_cmd_t  cur_cmd4,
    output logic               dac_busy,
    output logic               dac_sclk,
    output logic               dac_mosi,
    output logic               dac_csel
);
    import qla_pkg::*;

    localparam int DIV_W = $clog2(`DAC_CLK_DIV);

    dac_state_t                  state;
    logic                        pend;          // Request waiting for the shifter
    logic                        start;
    logic [DIV_W-1:0]            div_cnt;
    logic                        tick;          // Half period done
    logic [4:0]                  bit_cnt;       // Falling edges in this frame
    logic [1:0]                  frame_cnt;     // Frame index = channel - 1
    logic [`DAC_FRAME_BITS-1:0]  shreg;
    cur_cmd_t                    snap [1:3];    // Commands for frames two to four

    // Frame layout {cmd, addr, data}
    function automatic logic [`DAC_FRAME_BITS-1:0] make_frame(
        input logic [1:0] idx,
        input cur_cmd_t   cur
    );
        return {`DAC_CMD_WRITE_UPDATE, 2'b00, idx, cur};
    endfunction

    assign start    = (state == DAC_IDLE) & pend;
    assign tick     = (div_cnt == '0);
    assign dac_busy = (state != DAC_IDLE);
    assign dac_mosi = shreg[`DAC_FRAME_BITS-1];     // MSB first

    // ----------------------------------------
    // Shifter FSM
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            state     <= DAC_IDLE;
            pend      <= 1'b0;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            frame_cnt <= '0;
            dac_sclk  <= 1'b0;
            dac_csel  <= 1'b1;
        end else begin
            // Requests during busy merge into one
            if (dac_update_req)
                pend <= 1'b1;
            else if (start)
                pend <= 1'b0;
            if (state != DAC_IDLE)
                div_cnt <= tick ? DIV_W'(`DAC_CLK_DIV - 1) : div_cnt - 1'b1;
            case (state)
                DAC_IDLE: if (start) begin
                    frame_cnt <= 2'd0;
                    div_cnt   <= DIV_W'(`DAC_CLK_DIV - 1);
                    dac_csel  <= 1'b0;
                    state     <= DAC_SELECT;
                end
                DAC_SELECT: if (tick) begin     // First low half done
                    dac_sclk <= 1'b1;
                    bit_cnt  <= '0;
                    state    <= DAC_SHIFT;
                end
                DAC_SHIFT: if (tick) begin
                    dac_sclk <= ~dac_sclk;
                    if (dac_sclk) begin         // Falling edge launches next bit
                        if (bit_cnt == 5'(`DAC_FRAME_BITS - 1)) begin
                            dac_csel <= 1'b1;
                            state    <= DAC_GAP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                DAC_GAP: if (tick) begin
                    if (frame_cnt == 2'd3) begin
                        state <= DAC_IDLE;      // Fourth frame out
                    end else begin
                        frame_cnt <= frame_cnt + 1'b1;
                        dac_csel  <= 1'b0;
                        state     <= DAC_SELECT;
                    end
                end
                default: state <= DAC_IDLE;
            endcase
        end
    end

    // Snapshot and shift register
    always_ff @(posedge sysclk) begin
        if (start) begin
            snap[1] <= cur_cmd2;
            snap[2] <= cur_cmd3;
            snap[3] <= cur_cmd4;
            shreg   <= make_frame(2'd0, cur_cmd1);
        end else if (state == DAC_SHIFT && tick && dac_sclk) begin
            shreg <= {shreg[`DAC_FRAME_BITS-2:0], 1'b0};
        end else if (state == DAC_GAP && tick && frame_cnt != 2'd3) begin
            shreg <= make_frame(frame_cnt + 1'b1, snap[frame_cnt + 1'b1]);
        end
    end

endmodule

//--- hw/qla_core_top.sv
// ----------------------------------------
// Amp register core top level, wiring only
// ----------------------------------------

`timescale 1ns/1ps
`include "qla_consts.svh"

module qla_core_top (
    input  logic                      sysclk,
    input  logic                      reset,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  qla_pkg::reg_addr_t        wb_adr,
    input  qla_pkg::reg_data_t        wb_dat_w,
    input  qla_pkg::chan_idx_t        board_id,       // Rotary switch
    input  logic [`QLA_NUM_CHAN-1:0]  amp_fault_n,    // Channel 1 in bit 0
    output qla_pkg::reg_data_t        wb_dat_r,
    output logic                      wb_ack,
    output logic [`QLA_NUM_CHAN-1:0]  amp_disable_pin,
    output logic                      dac_sclk,
    output logic                      dac_mosi,
    output logic                      dac_csel,
    output logic                      dac_busy
);
    import qla_pkg::*;

    logic       reg_wen;
    reg_addr_t  reg_waddr;
    reg_data_t  reg_wdata;
    logic       amp_cmd_wen;
    logic       dac_update_req;
    cur_cmd_t   cur_cmd [1:`QLA_NUM_CHAN];      // Per-axis commanded current
    reg_data_t  mtr_status [1:`QLA_NUM_CHAN];

    // Host side
    qla_bus_slave u_bus (
        .sysclk(sysclk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .board_id(board_id), .amp_disable_pin(amp_disable_pin),
        .ch_cur_cmd1(cur_cmd[1]), .ch_cur_cmd2(cur_cmd[2]),
        .ch_cur_cmd3(cur_cmd[3]), .ch_cur_cmd4(cur_cmd[4]),
        .ch_status1(mtr_status[1]), .ch_status2(mtr_status[2]),
        .ch_status3(mtr_status[3]), .ch_status4(mtr_status[4]),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .amp_cmd_wen(amp_cmd_wen), .dac_update_req(dac_update_req)
    );

    // One channel per axis
    for (genvar k = 1; k <= `QLA_NUM_CHAN; k++) begin : g_chan
        motor_channel #(.CHANNEL(k)) u_chan (
            .sysclk(sysclk), .reset(reset),
            .reg_wen(reg_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
            .amp_cmd_wen(amp_cmd_wen), .amp_fault_n(amp_fault_n[k-1]),
            .cur_cmd(cur_cmd[k]), .amp_disable_pin(amp_disable_pin[k-1]),
            .status(mtr_status[k])
        );
    end

    // Quad DAC side
    dac_spi_ctrl u_dac (
        .sysclk(sysclk), .reset(reset), .dac_update_req(dac_update_req),
        .cur_cmd1(cur_cmd[1]), .cur_cmd2(cur_cmd[2]),
        .cur_cmd3(cur_cmd[3]), .cur_cmd4(cur_cmd[4]),
        .dac_busy(dac_busy), .dac_sclk(dac_sclk),
        .dac_mosi(dac_mosi), .dac_csel(dac_csel)
    );

endmodule

//--- tb/tb_qla_core.sv
// ----------------------------------------
// Testbench for the amp register core:
// file-driven bus cases, DAC frame monitor
// ----------------------------------------

`timescale 1ns/1ps
`include "qla_consts.svh"

module tb_qla_core;
    import qla_pkg::*;

    localparam int UPDATE_CYCLES  = 800;                 // Four frames, worst case
    localparam int TIMEOUT_CYCLES = 25 * UPDATE_CYCLES;  // Case budget with margin

    logic       sysclk;
    logic       reset;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    reg_addr_t  wb_adr;
    reg_data_t  wb_dat_w;
    reg_data_t  wb_dat_r;
    logic       wb_ack;
    chan_idx_t  board_id;
    logic [3:0] amp_fault_n;
    logic [3:0] amp_disable_pin;
    logic       dac_sclk;
    logic       dac_mosi;
    logic       dac_csel;
    logic       dac_busy;

    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    cur_cmd_t   cur_model [16];                          // Indexed by channel field
    logic [23:0] frames [$];                             // Frames seen on the DAC bus
    logic [23:0] mon_shift;
    int         mon_bits = 0;

    qla_core_top uut (
        .sysclk(sysclk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .board_id(board_id), .amp_fault_n(amp_fault_n),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .amp_disable_pin(amp_disable_pin),
        .dac_sclk(dac_sclk), .dac_mosi(dac_mosi), .dac_csel(dac_csel), .dac_busy(dac_busy)
    );

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;                    // 20 ns period
    end

    // Run limit
    always @(posedge sysclk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Summary: %0d checks, %0d errors", checks, errors + 1);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ----------------------------------------
    // DAC frame monitor
    // ----------------------------------------
    always @(posedge dac_sclk) begin
        if (dac_csel === 1'b0) begin
            mon_shift = {mon_shift[22:0], dac_mosi};     // Receiver samples on rise
            mon_bits  = mon_bits + 1;
        end
    end

    always @(posedge dac_csel) begin
        if (mon_bits == `DAC_FRAME_BITS)
            frames.push_back(mon_shift);
        else if (mon_bits != 0) begin
            $display("DAC error: frame of %0d bits at %0t", mon_bits, $time);
            errors = errors + 1;
        end
        mon_bits = 0;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    // One Wishbone classic cycle, called on a falling edge
    task automatic bus_access(input logic we, input reg_addr_t adr, input reg_data_t wdat,
                              output reg_data_t rdat);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do begin
            @(negedge sysclk);
            waited = waited + 1;
        end while (wb_ack !== 1'b1 && waited < 16);
        if (wb_ack !== 1'b1) begin
            $display("Bus error: no ack for address %h at %0t", adr, $time);
            errors = errors + 1;
        end
        rdat   = wb_dat_r;                               // Valid while ack high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int n;
        n = 0;
        while (dac_busy !== level && n < limit) begin
            @(negedge sysclk);
            n = n + 1;
        end
        if (dac_busy !== level) begin
            $display("DAC error: dac_busy not %0d after %0d cycles at %0t", level, limit, $time);
            errors = errors + 1;
        end
    endtask

    // Frames in channel order: command, channel minus one, current
    task automatic check_frames(input int sets);
        logic [23:0] exp_frame;
        check_value("frame count", frames.size(), sets * 4);
        for (int i = 0; i < frames.size() && i < sets * 4; i++) begin
            exp_frame = {`DAC_CMD_WRITE_UPDATE, 4'(i % 4), cur_model[4'(i % 4 + 1)]};
            check_value($sformatf("frame %0d", i), {8'd0, frames[i]}, {8'd0, exp_frame});
        end
    endtask

    task automatic run_case(input string op, input string a, input string b);
        reg_addr_t adr;
        reg_data_t dat;
        reg_data_t rdat;
        reg_data_t exp;
        int        n;
        adr = 16'(a.atohex());
        if (op == "W") begin
            if (b == "rand")
                dat = {16'd0, 16'($urandom())};
            else
                dat = b.atohex();
            bus_access(1'b1, adr, dat, rdat);
            if (adr[15:12] == 4'd0 && adr[7:4] >= 4'd1 && adr[7:4] <= 4'd4 && adr[3:0] == 4'd1)
                cur_model[adr[7:4]] = dat[15:0];         // Commanded current register
            repeat (2) @(negedge sysclk);                // Disable pin settles
        end else if (op == "R") begin
            if (b == "cur")
                exp = {16'd0, cur_model[adr[7:4]]};
            else
                exp = b.atohex();
            bus_access(1'b0, adr, 32'd0, rdat);
            check_value($sformatf("read %h", adr), rdat, exp);
            if (adr == 16'h0000)
                check_value("amp_disable_pin", {28'd0, amp_disable_pin}, {28'd0, exp[3:0]});
        end else if (op == "F") begin
            amp_fault_n = 4'(a.atohex());
            repeat (4) @(negedge sysclk);                // Sync, latch, then pin
        end else if (op == "U" || op == "B") begin
            n = (op == "B") ? a.atoi() : 0;
            frames.delete();
            bus_access(1'b1, 16'h0001, 32'd0, rdat);
            wait_busy(1'b1, 8);
            for (int k = 0; k < n; k++)
                bus_access(1'b1, 16'h0001, 32'd0, rdat); // Requests while busy
            wait_busy(1'b0, 2 * UPDATE_CYCLES);
            if (n > 0) begin
                wait_busy(1'b1, 8);                      // Merged pending update
                wait_busy(1'b0, 2 * UPDATE_CYCLES);
            end
            repeat (4) @(negedge sysclk);                // No further set may start
            check_value("dac_busy idle", {31'd0, dac_busy}, 32'd0);
            check_value("dac_csel idle", {31'd0, dac_csel}, 32'd1);
            check_frames((n > 0) ? 2 : 1);
        end else begin
            $display("Case error: unknown operation %s", op);
            errors = errors + 1;
        end
    endtask

    function automatic bit is_space(input byte c);
        return c == " " || c == "\t" || c == "\n" || c == "\r";
    endfunction

    function automatic string next_token(input string s, inout int pos);
        int start;
        while (pos < s.len() && is_space(s.getc(pos)))
            pos++;
        start = pos;
        while (pos < s.len() && !is_space(s.getc(pos)))
            pos++;
        return (pos > start) ? s.substr(start, pos - 1) : "";
    endfunction

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int    fd;
        int    pos;
        string line;
        string op;
        string tok1;
        string tok2;
        void'($urandom(32'he70710ca));
        reset       = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        board_id    = 4'ha;
        amp_fault_n = 4'hf;                              // No faults
        for (int i = 0; i < 16; i++)
            cur_model[i] = '0;
        repeat (3) @(posedge sysclk);
        @(negedge sysclk);
        reset = 1'b0;
        fd = $fopen("tb/qla_cases.txt", "r");
        if (fd == 0) begin
            $display("File error: cannot open tb/qla_cases.txt");
            errors = errors + 1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                pos = 0;
                op  = next_token(line, pos);
                if (op == "" || op.getc(0) == "#")
                    continue;                            // Blank or column notes
                tok1 = next_token(line, pos);
                tok2 = next_token(line, pos);
                run_case(op, tok1, tok2);
            end
            $fclose(fd);
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- project.f
+incdir+hw
hw/qla_pkg.sv
hw/qla_bus_slave.sv
hw/motor_channel.sv
hw/dac_spi_ctrl.sv
hw/qla_core_top.sv
tb/tb_qla_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the amp register core testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --top-module tb_qla_core -f project.f -o sim_qla \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_qla > "$LOG" 2>&1 \
    || echo "Simulator exited with an error status" >> "$LOG"
cat "$LOG"

grep -q -F '*** FAILED ***' "$LOG" && { echo "Simulation reported failure"; exit 1; }
grep -q -F '*** PASSED ***' "$LOG" || { echo "Simulation did not finish"; exit 1; }
exit 0

//--- tb/qla_cases.txt
# op addr data  : W write (data rand = random current), R read (expect cur = last current)
# F pins = amp_fault_n nibble, U = DAC update, B n = update plus n requests while busy
R 0000 0A00000F
R 001C 00000005
W 0011 rand
W 0021 rand
W 0031 rand
W 0041 FFFF1234
R 0011 cur
R 0021 cur
R 0031 cur
R 0041 cur
W 0031 rand
R 0021 cur
R 0031 cur
W 0000 00000105
R 0000 0A00000E
R 001C 00000004
W 0000 00000F0F
R 0000 0A000000
F D
R 002C 00000003
R 0000 0A000002
F F
R 002C 00000007
W 0000 00000202
R 002C 00000004
W 0000 00000400
R 0000 0A000004
U
W 0011 rand
B 1
B 2
W 0052 12345678
W 1011 0000AAAA
R 0011 cur
R 0002 00000000
R 0012 00000000
R 0051 00000000
R 1011 00000000
R 000C 00000000
